/* common/core_pkg.sv */
package core_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////
	localparam int num_stations = 4;
	localparam int rob_depth = 8;
	localparam int tag_width = 3;
	localparam int reg_count = 16;
	localparam int reg_width = 4;
	localparam int data_width = 32;

	// opcodes
	localparam logic [3:0] op_add = 4'h1;
	localparam logic [3:0] op_sub = 4'h2;
	localparam logic [3:0] op_addi = 4'h3;

	// low 20 bits hold either rs2 or an immediate
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [reg_width-1:0] rd;
			logic [reg_width-1:0] rs1;
			logic [reg_width-1:0] rs2;
			logic [15:0] pad;
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [reg_width-1:0] rd;
			logic [reg_width-1:0] rs1;
			logic [19:0] imm;
		} i;
	} inst_word;

endpackage

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic rst_n,
	input logic [core_pkg::reg_width-1:0] rd_idx_a,
	input logic [core_pkg::reg_width-1:0] rd_idx_b,
	input logic rename,
	input logic [core_pkg::reg_width-1:0] rename_idx,
	input logic [core_pkg::tag_width-1:0] rename_tag,
	input logic write,
	input logic [core_pkg::reg_width-1:0] write_idx,
	input logic [core_pkg::tag_width-1:0] write_tag,
	input logic [core_pkg::data_width-1:0] write_data,
	output logic [core_pkg::data_width-1:0] val_a,
	output logic busy_a,
	output logic [core_pkg::tag_width-1:0] tag_a,
	output logic [core_pkg::data_width-1:0] val_b,
	output logic busy_b,
	output logic [core_pkg::tag_width-1:0] tag_b
);
	logic [core_pkg::data_width-1:0] regs [core_pkg::reg_count];
	logic [core_pkg::reg_count-1:0] busy;
	logic [core_pkg::tag_width-1:0] tags [core_pkg::reg_count];

	// r0 reads zero
	assign val_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign busy_a = busy[rd_idx_a];
	assign tag_a = tags[rd_idx_a];
	assign val_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];
	assign busy_b = busy[rd_idx_b];
	assign tag_b = tags[rd_idx_b];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			for (int i = 0; i < core_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (write && write_idx != '0) begin
				regs[write_idx] <= write_data;
				// only the last writer clears busy
				if (busy[write_idx] && tags[write_idx] == write_tag) begin
					busy[write_idx] <= 1'b0;
				end
			end
			// a new rename overrides the retiring one
			if (rename && rename_idx != '0) begin
				busy[rename_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rename && rename_idx != '0) begin
			tags[rename_idx] <= rename_tag;
		end
	end

endmodule

/* hw/issue_unit.sv */
`timescale 1ns/1ps

module issue_unit (
	input logic clk,
	input logic rst_n,
	input logic in_req,
	input core_pkg::inst_word in_inst,
	input logic [core_pkg::data_width-1:0] rf_val_a,
	input logic rf_busy_a,
	input logic [core_pkg::tag_width-1:0] rf_tag_a,
	input logic [core_pkg::data_width-1:0] rf_val_b,
	input logic rf_busy_b,
	input logic [core_pkg::tag_width-1:0] rf_tag_b,
	input logic [core_pkg::num_stations-1:0] station_busy,
	input logic rob_full,
	input logic [core_pkg::tag_width-1:0] alloc_tag,
	input logic look_done_a,
	input logic [core_pkg::data_width-1:0] look_val_a,
	input logic look_done_b,
	input logic [core_pkg::data_width-1:0] look_val_b,
	input logic cdb_valid,
	input logic [core_pkg::tag_width-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	output logic in_ack,
	output logic [core_pkg::reg_width-1:0] rd_idx_a,
	output logic [core_pkg::reg_width-1:0] rd_idx_b,
	output logic rename,
	output logic [core_pkg::reg_width-1:0] rename_idx,
	output logic [core_pkg::num_stations-1:0] dispatch,
	output logic [3:0] disp_op,
	output logic [core_pkg::tag_width-1:0] disp_tag,
	output logic [core_pkg::data_width-1:0] disp_a_val,
	output logic disp_a_valid,
	output logic [core_pkg::tag_width-1:0] disp_a_tag,
	output logic [core_pkg::data_width-1:0] disp_b_val,
	output logic disp_b_valid,
	output logic [core_pkg::tag_width-1:0] disp_b_tag,
	output logic alloc,
	output logic [core_pkg::reg_width-1:0] alloc_rd,
	output logic [core_pkg::tag_width-1:0] look_tag_a,
	output logic [core_pkg::tag_width-1:0] look_tag_b
);
	logic is_addi;
	logic [core_pkg::data_width-1:0] imm_ext;
	logic [core_pkg::num_stations-1:0] free_sel;
	logic fire;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////
	assign is_addi = in_inst.r.opcode == core_pkg::op_addi;
	assign imm_ext = $signed(in_inst.i.imm);
	assign rd_idx_a = in_inst.r.rs1;
	assign rd_idx_b = in_inst.r.rs2;
	assign look_tag_a = rf_tag_a;
	assign look_tag_b = rf_tag_b;

	// lowest idle station wins
	always_comb begin
		free_sel = '0;
		for (int i = core_pkg::num_stations - 1; i >= 0; i--) begin
			if (!station_busy[i]) begin
				free_sel = '0;
				free_sel[i] = 1'b1;
			end
		end
	end

	assign fire = in_req && !in_ack && !rob_full && (free_sel != '0);
	assign dispatch = free_sel & {core_pkg::num_stations{fire}};
	assign alloc = fire;
	assign alloc_rd = in_inst.r.rd;
	assign rename = fire && in_inst.r.rd != '0;
	assign rename_idx = in_inst.r.rd;
	assign disp_op = is_addi ? core_pkg::op_add : in_inst.r.opcode;
	assign disp_tag = alloc_tag;

	////////////////////////////////////////
	// operands: rf, then rob, then bus
	////////////////////////////////////////
	always_comb begin
		disp_a_valid = 1'b1;
		disp_a_val = rf_val_a;
		disp_a_tag = rf_tag_a;
		if (rf_busy_a) begin
			if (look_done_a) begin
				disp_a_val = look_val_a;
			end else if (cdb_valid && cdb_tag == rf_tag_a) begin
				disp_a_val = cdb_data;
			end else begin
				disp_a_valid = 1'b0;
			end
		end
	end

	always_comb begin
		disp_b_valid = 1'b1;
		disp_b_val = rf_val_b;
		disp_b_tag = rf_tag_b;
		if (is_addi) begin
			disp_b_val = imm_ext;
		end else if (rf_busy_b) begin
			if (look_done_b) begin
				disp_b_val = look_val_b;
			end else if (cdb_valid && cdb_tag == rf_tag_b) begin
				disp_b_val = cdb_data;
			end else begin
				disp_b_valid = 1'b0;
			end
		end
	end

	// four-phase input handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_ack <= 1'b0;
		end else if (fire) begin
			in_ack <= 1'b1;
		end else if (in_ack && !in_req) begin
			in_ack <= 1'b0;
		end
	end

endmodule

/* alu_station/alu_station.sv */
`timescale 1ns/1ps

module alu_station (
	input logic clk,
	input logic rst_n,
	input logic dispatch,
	input logic [3:0] op,
	input logic [core_pkg::tag_width-1:0] dest_tag,
	input logic [core_pkg::data_width-1:0] a_val,
	input logic a_valid,
	input logic [core_pkg::tag_width-1:0] a_tag,
	input logic [core_pkg::data_width-1:0] b_val,
	input logic b_valid,
	input logic [core_pkg::tag_width-1:0] b_tag,
	input logic cdb_valid,
	input logic [core_pkg::tag_width-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	input logic grant,
	output logic busy,
	output logic result_req,
	output logic [core_pkg::tag_width-1:0] result_tag,
	output logic [core_pkg::data_width-1:0] result_data
);
	logic is_sub;
	logic [core_pkg::tag_width-1:0] tag_q;
	logic [core_pkg::data_width-1:0] a_q;
	logic [core_pkg::data_width-1:0] b_q;
	logic [core_pkg::tag_width-1:0] a_tag_q;
	logic [core_pkg::tag_width-1:0] b_tag_q;
	logic a_ok;
	logic b_ok;
	logic a_hit;
	logic b_hit;
	logic ready;

	// bus snoop for waiting operands
	assign a_hit = busy && !a_ok && cdb_valid && cdb_tag == a_tag_q;
	assign b_hit = busy && !b_ok && cdb_valid && cdb_tag == b_tag_q;
	assign ready = busy && a_ok && b_ok && !result_req;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			result_req <= 1'b0;
			a_ok <= 1'b0;
			b_ok <= 1'b0;
		end else if (dispatch) begin
			busy <= 1'b1;
			a_ok <= a_valid;
			b_ok <= b_valid;
		end else begin
			if (a_hit) begin
				a_ok <= 1'b1;
			end
			if (b_hit) begin
				b_ok <= 1'b1;
			end
			if (ready) begin
				result_req <= 1'b1;
			end
			// freed in the grant cycle
			if (grant) begin
				result_req <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			is_sub <= op == core_pkg::op_sub;
			tag_q <= dest_tag;
			a_q <= a_val;
			a_tag_q <= a_tag;
			b_q <= b_val;
			b_tag_q <= b_tag;
		end else begin
			if (a_hit) begin
				a_q <= cdb_data;
			end
			if (b_hit) begin
				b_q <= cdb_data;
			end
		end
		// 32-bit wraparound
		if (ready) begin
			result_tag <= tag_q;
			result_data <= is_sub ? a_q - b_q : a_q + b_q;
		end
	end

endmodule

/* hw/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
	input logic clk,
	input logic rst_n,
	input logic [core_pkg::num_stations-1:0] result_req,
	input logic [core_pkg::num_stations-1:0][core_pkg::tag_width-1:0] result_tag,
	input logic [core_pkg::num_stations-1:0][core_pkg::data_width-1:0] result_data,
	output logic [core_pkg::num_stations-1:0] grant,
	output logic cdb_valid,
	output logic [core_pkg::tag_width-1:0] cdb_tag,
	output logic [core_pkg::data_width-1:0] cdb_data
);
	logic [core_pkg::tag_width-1:0] win_tag;
	logic [core_pkg::data_width-1:0] win_data;

	// fixed priority, index 0 first
	always_comb begin
		grant = '0;
		for (int i = core_pkg::num_stations - 1; i >= 0; i--) begin
			if (result_req[i]) begin
				grant = '0;
				grant[i] = 1'b1;
			end
		end
	end

	// one-hot select of the winner
	always_comb begin
		win_tag = '0;
		win_data = '0;
		for (int i = 0; i < core_pkg::num_stations; i++) begin
			win_tag |= result_tag[i] & {core_pkg::tag_width{grant[i]}};
			win_data |= result_data[i] & {core_pkg::data_width{grant[i]}};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= grant != '0;
		end
	end

	always_ff @(posedge clk) begin
		cdb_tag <= win_tag;
		cdb_data <= win_data;
	end

endmodule

/* rob/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input logic [core_pkg::reg_width-1:0] alloc_rd,
	input logic cdb_valid,
	input logic [core_pkg::tag_width-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	input logic [core_pkg::tag_width-1:0] look_tag_a,
	input logic [core_pkg::tag_width-1:0] look_tag_b,
	input logic commit_ack,
	output logic [core_pkg::tag_width-1:0] alloc_tag,
	output logic full,
	output logic look_done_a,
	output logic [core_pkg::data_width-1:0] look_val_a,
	output logic look_done_b,
	output logic [core_pkg::data_width-1:0] look_val_b,
	output logic rf_write,
	output logic [core_pkg::reg_width-1:0] rf_write_idx,
	output logic [core_pkg::tag_width-1:0] rf_write_tag,
	output logic [core_pkg::data_width-1:0] rf_write_data,
	output logic commit_req,
	output logic [core_pkg::reg_width-1:0] commit_rd,
	output logic [core_pkg::data_width-1:0] commit_data
);
	logic [core_pkg::reg_width-1:0] ent_rd [core_pkg::rob_depth];
	logic [core_pkg::data_width-1:0] ent_val [core_pkg::rob_depth];
	logic [core_pkg::rob_depth-1:0] ent_done;
	logic [core_pkg::tag_width-1:0] head;
	logic [core_pkg::tag_width-1:0] tail;
	logic [core_pkg::tag_width:0] count;
	logic ack_wait;
	logic retire_start;
	logic retire_done;

	assign alloc_tag = tail;
	assign full = count == core_pkg::rob_depth;

	// operand lookup for the issue unit
	assign look_done_a = ent_done[look_tag_a];
	assign look_val_a = ent_val[look_tag_a];
	assign look_done_b = ent_done[look_tag_b];
	assign look_val_b = ent_val[look_tag_b];

	////////////////////////////////////////
	// retirement
	////////////////////////////////////////
	// start once the previous ack has dropped
	assign retire_start = !commit_req && (!ack_wait || !commit_ack) &&
		count != '0 && ent_done[head];
	assign retire_done = commit_req && commit_ack;

	// r0 still retires, just no rf write
	assign rf_write = retire_start && ent_rd[head] != '0;
	assign rf_write_idx = ent_rd[head];
	assign rf_write_tag = head;
	assign rf_write_data = ent_val[head];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			ent_done <= '0;
			commit_req <= 1'b0;
			ack_wait <= 1'b0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
				ent_done[tail] <= 1'b0;
			end
			if (cdb_valid) begin
				ent_done[cdb_tag] <= 1'b1;
			end
			if (retire_start) begin
				commit_req <= 1'b1;
			end
			if (retire_done) begin
				commit_req <= 1'b0;
				ack_wait <= 1'b1;
				head <= head + 1'b1;
			end else if (ack_wait && !commit_ack) begin
				ack_wait <= 1'b0;
			end
			if (alloc && !retire_done) begin
				count <= count + 1'b1;
			end else if (!alloc && retire_done) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			ent_rd[tail] <= alloc_rd;
		end
		if (cdb_valid) begin
			ent_val[cdb_tag] <= cdb_data;
		end
		// held stable for the whole handshake
		if (retire_start) begin
			commit_rd <= ent_rd[head];
			commit_data <= ent_val[head];
		end
	end

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core (
	input logic clk,
	input logic rst_n,
	input logic in_req,
	input core_pkg::inst_word in_inst,
	input logic commit_ack,
	output logic in_ack,
	output logic commit_req,
	output logic [core_pkg::reg_width-1:0] commit_rd,
	output logic [core_pkg::data_width-1:0] commit_data
);
	// register file read and rename
	logic [core_pkg::reg_width-1:0] rd_idx_a;
	logic [core_pkg::reg_width-1:0] rd_idx_b;
	logic [core_pkg::data_width-1:0] rf_val_a;
	logic [core_pkg::data_width-1:0] rf_val_b;
	logic rf_busy_a;
	logic rf_busy_b;
	logic [core_pkg::tag_width-1:0] rf_tag_a;
	logic [core_pkg::tag_width-1:0] rf_tag_b;
	logic rename;
	logic [core_pkg::reg_width-1:0] rename_idx;

	// dispatch
	logic [core_pkg::num_stations-1:0] dispatch;
	logic [core_pkg::num_stations-1:0] station_busy;
	logic [3:0] disp_op;
	logic [core_pkg::tag_width-1:0] disp_tag;
	logic [core_pkg::data_width-1:0] disp_a_val;
	logic disp_a_valid;
	logic [core_pkg::tag_width-1:0] disp_a_tag;
	logic [core_pkg::data_width-1:0] disp_b_val;
	logic disp_b_valid;
	logic [core_pkg::tag_width-1:0] disp_b_tag;

	// rob
	logic alloc;
	logic rob_full;
	logic [core_pkg::reg_width-1:0] alloc_rd;
	logic [core_pkg::tag_width-1:0] alloc_tag;
	logic [core_pkg::tag_width-1:0] look_tag_a;
	logic [core_pkg::tag_width-1:0] look_tag_b;
	logic look_done_a;
	logic look_done_b;
	logic [core_pkg::data_width-1:0] look_val_a;
	logic [core_pkg::data_width-1:0] look_val_b;
	logic rf_write;
	logic [core_pkg::reg_width-1:0] rf_write_idx;
	logic [core_pkg::tag_width-1:0] rf_write_tag;
	logic [core_pkg::data_width-1:0] rf_write_data;

	// results and bus
	logic [core_pkg::num_stations-1:0] result_req;
	logic [core_pkg::num_stations-1:0][core_pkg::tag_width-1:0] result_tag;
	logic [core_pkg::num_stations-1:0][core_pkg::data_width-1:0] result_data;
	logic [core_pkg::num_stations-1:0] grant;
	logic cdb_valid;
	logic [core_pkg::tag_width-1:0] cdb_tag;
	logic [core_pkg::data_width-1:0] cdb_data;

	issue_unit issue_unit_i (
		.clk, .rst_n, .in_req, .in_inst,
		.rf_val_a, .rf_busy_a, .rf_tag_a, .rf_val_b, .rf_busy_b, .rf_tag_b,
		.station_busy, .rob_full, .alloc_tag,
		.look_done_a, .look_val_a, .look_done_b, .look_val_b,
		.cdb_valid, .cdb_tag, .cdb_data,
		.in_ack, .rd_idx_a, .rd_idx_b, .rename, .rename_idx, .dispatch,
		.disp_op, .disp_tag, .disp_a_val, .disp_a_valid, .disp_a_tag,
		.disp_b_val, .disp_b_valid, .disp_b_tag,
		.alloc, .alloc_rd, .look_tag_a, .look_tag_b
	);

	register_file register_file_i (
		.clk, .rst_n, .rd_idx_a, .rd_idx_b,
		.rename, .rename_idx, .rename_tag(alloc_tag),
		.write(rf_write), .write_idx(rf_write_idx),
		.write_tag(rf_write_tag), .write_data(rf_write_data),
		.val_a(rf_val_a), .busy_a(rf_busy_a), .tag_a(rf_tag_a),
		.val_b(rf_val_b), .busy_b(rf_busy_b), .tag_b(rf_tag_b)
	);

	for (genvar i = 0; i < core_pkg::num_stations; i++) begin : g_station
		alu_station alu_station_i (
			.clk, .rst_n, .dispatch(dispatch[i]),
			.op(disp_op), .dest_tag(disp_tag),
			.a_val(disp_a_val), .a_valid(disp_a_valid), .a_tag(disp_a_tag),
			.b_val(disp_b_val), .b_valid(disp_b_valid), .b_tag(disp_b_tag),
			.cdb_valid, .cdb_tag, .cdb_data, .grant(grant[i]),
			.busy(station_busy[i]), .result_req(result_req[i]),
			.result_tag(result_tag[i]), .result_data(result_data[i])
		);
	end

	cdb_arbiter cdb_arbiter_i (
		.clk, .rst_n, .result_req, .result_tag, .result_data,
		.grant, .cdb_valid, .cdb_tag, .cdb_data
	);

	reorder_buffer reorder_buffer_i (
		.clk, .rst_n, .alloc, .alloc_rd, .cdb_valid, .cdb_tag, .cdb_data,
		.look_tag_a, .look_tag_b, .commit_ack,
		.alloc_tag, .full(rob_full),
		.look_done_a, .look_val_a, .look_done_b, .look_val_b,
		.rf_write, .rf_write_idx, .rf_write_tag, .rf_write_data,
		.commit_req, .commit_rd, .commit_data
	);

endmodule

/* tb/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;

	localparam int inst_total = 231;
	localparam int cycle_limit = 40 * inst_total + 400;

	logic clk;
	logic rst_n;
	logic in_req;
	core_pkg::inst_word in_inst;
	logic commit_ack;
	logic in_ack;
	logic commit_req;
	logic [core_pkg::reg_width-1:0] commit_rd;
	logic [core_pkg::data_width-1:0] commit_data;

	logic [core_pkg::data_width-1:0] model_regs [core_pkg::reg_count];
	logic [core_pkg::reg_width-1:0] exp_rd_q [$];
	logic [core_pkg::data_width-1:0] exp_data_q [$];

	int errors;
	int checks;
	int tests_run;
	int test_errors_start;
	int cycles;
	int in_delay_max;
	int commit_delay_max;
	int ack_delay;
	logic ack_hold;
	logic prev_in_ack;
	logic prev_commit_req;
	logic [core_pkg::reg_width-1:0] prev_rd;
	logic [core_pkg::data_width-1:0] prev_data;

	ooo_core ooo_core_i (
		.clk, .rst_n, .in_req, .in_inst, .commit_ack,
		.in_ack, .commit_req, .commit_rd, .commit_data
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("Done: errors found");
		$finish;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic core_pkg::inst_word make_reg_inst(input logic [3:0] op,
			input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2);
		core_pkg::inst_word w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.rs1 = rs1;
		w.r.rs2 = rs2;
		return w;
	endfunction

	function automatic core_pkg::inst_word make_imm_inst(input logic [3:0] rd,
			input logic [3:0] rs1, input logic [19:0] imm);
		core_pkg::inst_word w;
		w.i.opcode = core_pkg::op_addi;
		w.i.rd = rd;
		w.i.rs1 = rs1;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] model_exec(input core_pkg::inst_word inst);
		logic [31:0] a;
		logic [31:0] b;
		a = model_regs[inst.r.rs1];
		b = model_regs[inst.r.rs2];
		if (inst.r.opcode == core_pkg::op_addi) begin
			return a + {{12{inst.i.imm[19]}}, inst.i.imm};
		end else if (inst.r.opcode == core_pkg::op_sub) begin
			return a - b;
		end
		return a + b;
	endfunction

	////////////////////////////////////////
	// input port driver
	////////////////////////////////////////
	task automatic begin_send(input core_pkg::inst_word inst);
		logic [31:0] result;
		@(negedge clk);
		in_inst <= inst;
		in_req <= 1'b1;
		result = model_exec(inst);
		if (inst.r.rd != '0) begin
			model_regs[inst.r.rd] = result;
		end
		exp_rd_q.push_back(inst.r.rd);
		exp_data_q.push_back(result);
	endtask

	task automatic end_send();
		do @(negedge clk); while (!in_ack);
		repeat ($urandom % (in_delay_max + 1)) @(negedge clk);
		in_req <= 1'b0;
		do @(negedge clk); while (in_ack);
	endtask

	task automatic send(input core_pkg::inst_word inst);
		repeat ($urandom % (in_delay_max + 1)) @(negedge clk);
		begin_send(inst);
		end_send();
	endtask

	task automatic drain();
		while (exp_rd_q.size() != 0 || commit_req || commit_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == test_errors_start) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_errors_start);
		end
		test_errors_start = errors;
	endtask

	////////////////////////////////////////
	// commit port sink and checks
	////////////////////////////////////////
	task automatic check_commit();
		logic [3:0] exp_rd;
		logic [31:0] exp_data;
		checks++;
		assert (exp_rd_q.size() > 0) else begin
			$display("commit handshake with no instruction outstanding");
			errors++;
		end
		if (exp_rd_q.size() > 0) begin
			exp_rd = exp_rd_q.pop_front();
			exp_data = exp_data_q.pop_front();
			assert (commit_rd == exp_rd) else begin
				$display("FAIL commit_rd: got %h expected %h", commit_rd, exp_rd);
				errors++;
			end
			assert (commit_data == exp_data) else begin
				$display("FAIL commit_data: got %h expected %h", commit_data, exp_data);
				errors++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			commit_ack <= 1'b0;
			ack_delay = 0;
		end else if (commit_req && !commit_ack) begin
			if (ack_delay > 0) begin
				ack_delay = ack_delay - 1;
			end else if (!ack_hold) begin
				check_commit();
				commit_ack <= 1'b1;
				ack_delay = $urandom % (commit_delay_max + 1);
			end
		end else if (!commit_req && commit_ack) begin
			if (ack_delay > 0) begin
				ack_delay = ack_delay - 1;
			end else begin
				commit_ack <= 1'b0;
				ack_delay = $urandom % (commit_delay_max + 1);
			end
		end
	end

	// four-phase protocol on both ports
	always @(negedge clk) begin
		if (rst_n) begin
			if (!prev_in_ack && in_ack) begin
				assert (in_req) else begin
					$display("in_ack rose while in_req was low");
					errors++;
				end
			end
			if (prev_in_ack && !in_ack) begin
				assert (!in_req) else begin
					$display("in_ack fell while in_req was still high");
					errors++;
				end
			end
			if (!prev_commit_req && commit_req) begin
				assert (!commit_ack) else begin
					$display("commit_req rose before commit_ack had fallen");
					errors++;
				end
			end
			if (prev_commit_req && !commit_req) begin
				assert (commit_ack) else begin
					$display("commit_req fell without commit_ack");
					errors++;
				end
			end
			if (prev_commit_req && commit_req) begin
				assert (commit_rd == prev_rd && commit_data == prev_data) else begin
					$display("commit_rd or commit_data changed while commit_req was high");
					errors++;
				end
			end
		end
		prev_in_ack = in_ack;
		prev_commit_req = commit_req;
		prev_rd = commit_rd;
		prev_data = commit_data;
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////
	initial begin
		int unsigned first_draw;
		int sel;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		first_draw = $urandom(32'hc6ebadb3);
		rst_n = 1'b0;
		in_req = 1'b0;
		in_inst = '0;
		commit_ack = 1'b0;
		ack_hold = 1'b0;
		in_delay_max = 0;
		commit_delay_max = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_errors_start = 0;
		prev_in_ack = 1'b0;
		prev_commit_req = 1'b0;
		for (int i = 0; i < core_pkg::reg_count; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(negedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!in_ack && !commit_req) else begin
			$display("in_ack or commit_req high after reset");
			errors++;
		end

		send(make_imm_inst(4'd1, 4'd0, 20'h00005));
		send(make_imm_inst(4'd2, 4'd0, 20'hfffff));
		send(make_imm_inst(4'd3, 4'd0, 20'h80000));
		send(make_imm_inst(4'd4, 4'd0, 20'h7ffff));
		send(make_imm_inst(4'd5, 4'd0, 20'hfff38));
		send(make_imm_inst(4'd6, 4'd0, 20'h12345));
		drain();
		report_test("independent addi");

		// slow commit keeps results in the rob
		commit_delay_max = 3;
		send(make_imm_inst(4'd1, 4'd0, 20'd10));
		send(make_reg_inst(core_pkg::op_add, 4'd2, 4'd1, 4'd1));
		send(make_reg_inst(core_pkg::op_sub, 4'd3, 4'd1, 4'd2));
		send(make_reg_inst(core_pkg::op_add, 4'd1, 4'd3, 4'd2));
		send(make_reg_inst(core_pkg::op_sub, 4'd4, 4'd1, 4'd2));
		send(make_reg_inst(core_pkg::op_sub, 4'd4, 4'd4, 4'd3));
		send(make_reg_inst(core_pkg::op_add, 4'd5, 4'd4, 4'd4));
		send(make_reg_inst(core_pkg::op_sub, 4'd6, 4'd0, 4'd5));
		drain();
		report_test("dependent chain");

		commit_delay_max = 0;
		send(make_imm_inst(4'd0, 4'd0, 20'd7));
		send(make_imm_inst(4'd0, 4'd6, 20'd1));
		send(make_reg_inst(core_pkg::op_add, 4'd8, 4'd0, 4'd0));
		send(make_imm_inst(4'd9, 4'd0, 20'd3));
		send(make_reg_inst(core_pkg::op_sub, 4'd10, 4'd9, 4'd0));
		drain();
		report_test("r0 writes");

		ack_hold = 1'b1;
		for (int k = 0; k < 8; k++) begin
			send(make_imm_inst(4'(k + 1), 4'd0, 20'(k * 3 + 1)));
		end
		begin_send(make_reg_inst(core_pkg::op_add, 4'd9, 4'd1, 4'd2));
		repeat (30) begin
			@(negedge clk);
			assert (!in_ack) else begin
				$display("in_ack rose with eight instructions outstanding");
				errors++;
			end
		end
		ack_hold = 1'b0;
		end_send();
		send(make_reg_inst(core_pkg::op_sub, 4'd10, 4'd9, 4'd8));
		send(make_imm_inst(4'd11, 4'd10, 20'hffff0));
		send(make_reg_inst(core_pkg::op_add, 4'd1, 4'd11, 4'd7));
		drain();
		report_test("commit back-pressure");

		in_delay_max = 4;
		commit_delay_max = 4;
		for (int n = 0; n < 200; n++) begin
			sel = $urandom % 3;
			rd = 4'($urandom % 8);
			rs1 = 4'($urandom % 8);
			rs2 = 4'($urandom % 8);
			if (sel == 0) begin
				send(make_reg_inst(core_pkg::op_add, rd, rs1, rs2));
			end else if (sel == 1) begin
				send(make_reg_inst(core_pkg::op_sub, rd, rs1, rs2));
			end else begin
				send(make_imm_inst(rd, rs1, 20'($urandom)));
			end
		end
		drain();
		report_test("random mix");

		$display("%0d tests run, %0d commits checked, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* flist.f */
common/core_pkg.sv
hw/register_file.sv
hw/issue_unit.sv
alu_station/alu_station.sv
hw/cdb_arbiter.sv
rob/reorder_buffer.sv
hw/ooo_core.sv
tb/ooo_core_tb.sv
